// ==== rv_idex_defines.svh ====
`ifndef RV_IDEX_DEFINES_SVH
`define RV_IDEX_DEFINES_SVH

// datapath and pc width
`define XLEN 64

// register file geometry
`define REG_ADDR_W 5
`define REG_DEPTH 32

// pc value parked in the stage registers out of reset
`define RESET_PC 64'h0000_0000_8000_0000

`endif

// ==== rv_idex_pkg.sv ====
`default_nettype none
`include "rv_idex_defines.svh"

package rv_idex_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B                              // lui passes operand b straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_FROM_EX,
        FWD_FROM_WB
    } fwd_sel_e;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        alu_op_e                alu_op;
        logic                   use_imm;        // operand b from imm
        logic                   reg_we;         // never set for x0
        logic [`REG_ADDR_W-1:0] waddr;
        logic                   branch;
        logic                   bne;            // branch on not equal
        logic                   jal;
        logic                   jalr;
        logic                   ebreak;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       wdata;
    } ex_wb_t;

    // id/ex contents after reset with everything idle at the boot pc
    localparam id_ex_t id_ex_reset = '{
        valid:    1'b0,
        pc:       `RESET_PC,
        rs1_data: '0,
        rs2_data: '0,
        imm:      '0,
        alu_op:   ALU_ADD,
        use_imm:  1'b0,
        reg_we:   1'b0,
        waddr:    '0,
        branch:   1'b0,
        bne:      1'b0,
        jal:      1'b0,
        jalr:     1'b0,
        ebreak:   1'b0
    };

endpackage

`default_nettype wire

// ==== inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_idex_defines.svh"

module inst_decoder import rv_idex_pkg::*; (
    input  logic [31:0]            instr_i,
    input  logic                   instr_valid_i,
    input  logic [`XLEN-1:0]       pc_i,
    output id_ex_t                 dec_o,
    output logic [`REG_ADDR_W-1:0] rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] rs2_addr_o
);

    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       imm_b;
    logic [`XLEN-1:0]       imm_j;
    logic                   known;
    logic                   writes_rd;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];

    // sign extended immediates per format
    assign imm_i = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {{(`XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_b = {{(`XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{(`XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        dec_o        = '0;
        dec_o.pc     = pc_i;
        dec_o.alu_op = ALU_ADD;
        rs1_addr_o   = '0;                      // unused sources forward nothing
        rs2_addr_o   = '0;
        known        = 1'b1;
        writes_rd    = 1'b0;
        case (opcode)
            opc_op: begin
                rs1_addr_o = rs1;
                rs2_addr_o = rs2;
                writes_rd  = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec_o.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: dec_o.alu_op = ALU_SUB;
                    {7'h00, 3'b111}: dec_o.alu_op = ALU_AND;
                    {7'h00, 3'b110}: dec_o.alu_op = ALU_OR;
                    {7'h00, 3'b100}: dec_o.alu_op = ALU_XOR;
                    {7'h00, 3'b010}: dec_o.alu_op = ALU_SLT;
                    default:         known = 1'b0;
                endcase
            end
            opc_op_imm: begin
                rs1_addr_o    = rs1;
                writes_rd     = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_i;
                known         = (funct3 == 3'b000);     // addi only
            end
            opc_lui: begin
                writes_rd     = 1'b1;
                dec_o.use_imm = 1'b1;
                dec_o.imm     = imm_u;
                dec_o.alu_op  = ALU_PASS_B;
            end
            opc_branch: begin
                rs1_addr_o   = rs1;
                rs2_addr_o   = rs2;
                dec_o.imm    = imm_b;
                dec_o.branch = 1'b1;
                dec_o.bne    = funct3[0];
                known        = (funct3[2:1] == 2'b00);  // beq, bne
            end
            opc_jal: begin
                writes_rd = 1'b1;
                dec_o.imm = imm_j;
                dec_o.jal = 1'b1;
            end
            opc_jalr: begin
                rs1_addr_o = rs1;
                writes_rd  = 1'b1;
                dec_o.imm  = imm_i;
                dec_o.jalr = 1'b1;
                known      = (funct3 == 3'b000);
            end
            default: begin
                dec_o.ebreak = (instr_i == ebreak_word);
                known        = dec_o.ebreak;            // anything else is a bubble
            end
        endcase
        dec_o.valid  = instr_valid_i & known;
        dec_o.reg_we = writes_rd & (rd != '0);
        dec_o.waddr  = rd;
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_idex_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o
);

    logic [`XLEN-1:0] regs [`REG_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin     // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // async read without write-through
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== pipe_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_reg import rv_idex_pkg::*; #(
    parameter type      payload_t = ex_wb_t,
    parameter payload_t rst_val   = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t flushed;

    // bubble keeps the payload and only drops the valid bit
    always_comb begin
        flushed       = d_i;
        flushed.valid = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= rst_val;
        end else if (flush_i) begin             // flush wins over enable
            q_o <= flushed;
        end else if (en_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// ==== alu_exec.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_idex_defines.svh"

module alu_exec import rv_idex_pkg::*; (
    input  id_ex_t           ex_i,
    output ex_wb_t           wb_o,
    output logic             ex_dst_valid_o,
    output logic             redirect_o,
    output logic [`XLEN-1:0] redirect_pc_o,
    output logic             ebreak_o
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [`XLEN-1:0] link_pc;
    logic [`XLEN-1:0] br_target;
    logic [`XLEN-1:0] jalr_sum;
    logic             rs_equal;
    logic             take_branch;
    logic             is_jump;

    assign op_a = ex_i.rs1_data;
    assign op_b = ex_i.use_imm ? ex_i.imm : ex_i.rs2_data;

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    assign link_pc   = ex_i.pc + `XLEN'd4;
    assign br_target = ex_i.pc + ex_i.imm;
    assign jalr_sum  = ex_i.rs1_data + ex_i.imm;

    // beq / bne compare on raw register operands
    assign rs_equal    = (ex_i.rs1_data == ex_i.rs2_data);
    assign take_branch = ex_i.branch & (ex_i.bne ? !rs_equal : rs_equal);
    assign is_jump     = ex_i.jal | ex_i.jalr;

    assign redirect_o    = ex_i.valid & (take_branch | is_jump);
    assign redirect_pc_o = !ex_i.valid ? '0 :
                           ex_i.jalr   ? {jalr_sum[`XLEN-1:1], 1'b0} :
                                         br_target;
    assign ebreak_o      = ex_i.valid & ex_i.ebreak;

    assign ex_dst_valid_o = ex_i.valid & ex_i.reg_we;

    assign wb_o.valid = ex_dst_valid_o;                     // a writeback event
    assign wb_o.we    = ex_dst_valid_o;
    assign wb_o.waddr = ex_dst_valid_o ? ex_i.waddr : '0;
    assign wb_o.wdata = !ex_dst_valid_o ? '0 :
                        is_jump         ? link_pc :         // jal / jalr link value
                                          alu_res;

endmodule

`default_nettype wire

// ==== hazard_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_idex_defines.svh"

module hazard_ctrl import rv_idex_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [`REG_ADDR_W-1:0] ex_waddr_i,
    input  logic                   ex_dst_valid_i,
    input  logic [`REG_ADDR_W-1:0] wb_waddr_i,
    input  logic                   wb_dst_valid_i,
    input  logic                   redirect_i,
    input  logic                   ebreak_i,
    output fwd_sel_e               fwd1_sel_o,
    output fwd_sel_e               fwd2_sel_o,
    output logic                   id_flush_o,
    output logic                   halt_o
);

    logic halt_q;

    // youngest producer wins and x0 never forwards
    function automatic fwd_sel_e pick_src(
        input logic [`REG_ADDR_W-1:0] rs,
        input logic [`REG_ADDR_W-1:0] ex_waddr,
        input logic                   ex_hit_ok,
        input logic [`REG_ADDR_W-1:0] wb_waddr,
        input logic                   wb_hit_ok
    );
        fwd_sel_e sel;
        sel = FWD_REGFILE;
        if (rs != '0) begin
            if (ex_hit_ok && (rs == ex_waddr)) begin
                sel = FWD_FROM_EX;
            end else if (wb_hit_ok && (rs == wb_waddr)) begin
                sel = FWD_FROM_WB;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd1_sel_o = pick_src(rs1_addr_i, ex_waddr_i, ex_dst_valid_i,
                              wb_waddr_i, wb_dst_valid_i);
        fwd2_sel_o = pick_src(rs2_addr_i, ex_waddr_i, ex_dst_valid_i,
                              wb_waddr_i, wb_dst_valid_i);
    end

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halt_q <= 1'b0;
        end else if (ebreak_i) begin
            halt_q <= 1'b1;
        end
    end

    assign halt_o     = halt_q;
    assign id_flush_o = redirect_i | ebreak_i | halt_q;    // kill younger instr in id

endmodule

`default_nettype wire

// ==== rv_idex_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_idex_defines.svh"

module rv_idex_top import rv_idex_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid_i,
    input  logic [31:0]            instr_i,
    input  logic [`XLEN-1:0]       pc_i,
    output logic                   redirect_o,
    output logic [`XLEN-1:0]       redirect_pc_o,
    output logic                   wb_valid_o,
    output logic [`REG_ADDR_W-1:0] wb_waddr_o,
    output logic [`XLEN-1:0]       wb_wdata_o,
    output logic                   halt_o
);

    id_ex_t                 dec;
    id_ex_t                 id_ex_d;
    id_ex_t                 id_ex_q;
    ex_wb_t                 ex_wb_d;
    ex_wb_t                 ex_wb_q;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rf_rdata1;
    logic [`XLEN-1:0]       rf_rdata2;
    logic [`XLEN-1:0]       rs1_fwd;
    logic [`XLEN-1:0]       rs2_fwd;
    fwd_sel_e               fwd1_sel;
    fwd_sel_e               fwd2_sel;
    logic                   id_flush;
    logic                   ex_dst_valid;
    logic                   ebreak_ex;

    inst_decoder u_decoder (
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pc_i          (pc_i),
        .dec_o         (dec),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_i     (ex_wb_q.we),
        .waddr_i  (ex_wb_q.waddr),
        .wdata_i  (ex_wb_q.wdata),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // operand muxes where the ex result is the younger one
    assign rs1_fwd = (fwd1_sel == FWD_FROM_EX) ? ex_wb_d.wdata :
                     (fwd1_sel == FWD_FROM_WB) ? ex_wb_q.wdata : rf_rdata1;
    assign rs2_fwd = (fwd2_sel == FWD_FROM_EX) ? ex_wb_d.wdata :
                     (fwd2_sel == FWD_FROM_WB) ? ex_wb_q.wdata : rf_rdata2;

    assign id_ex_d = '{
        valid:    dec.valid,
        pc:       dec.pc,
        rs1_data: rs1_fwd,
        rs2_data: rs2_fwd,
        imm:      dec.imm,
        alu_op:   dec.alu_op,
        use_imm:  dec.use_imm,
        reg_we:   dec.reg_we,
        waddr:    dec.waddr,
        branch:   dec.branch,
        bne:      dec.bne,
        jal:      dec.jal,
        jalr:     dec.jalr,
        ebreak:   dec.ebreak
    };

    pipe_reg #(
        .payload_t (id_ex_t),
        .rst_val   (id_ex_reset)
    ) u_id_ex (
        .clk     (clk),
        .rst_n   (rst_n),
        .en_i    (1'b1),                // no stalls in this slice
        .flush_i (id_flush),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    alu_exec u_alu_exec (
        .ex_i           (id_ex_q),
        .wb_o           (ex_wb_d),
        .ex_dst_valid_o (ex_dst_valid),
        .redirect_o     (redirect_o),
        .redirect_pc_o  (redirect_pc_o),
        .ebreak_o       (ebreak_ex)
    );

    pipe_reg #(
        .payload_t (ex_wb_t)
    ) u_ex_wb (
        .clk     (clk),
        .rst_n   (rst_n),
        .en_i    (1'b1),
        .flush_i (1'b0),
        .d_i     (ex_wb_d),
        .q_o     (ex_wb_q)
    );

    hazard_ctrl u_hazard_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .ex_waddr_i     (ex_wb_d.waddr),
        .ex_dst_valid_i (ex_dst_valid),
        .wb_waddr_i     (ex_wb_q.waddr),
        .wb_dst_valid_i (ex_wb_q.valid),
        .redirect_i     (redirect_o),
        .ebreak_i       (ebreak_ex),
        .fwd1_sel_o     (fwd1_sel),
        .fwd2_sel_o     (fwd2_sel),
        .id_flush_o     (id_flush),
        .halt_o         (halt_o)
    );

    assign wb_valid_o = ex_wb_q.valid;
    assign wb_waddr_o = ex_wb_q.waddr;
    assign wb_wdata_o = ex_wb_q.wdata;

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(period_ns / 2) clk_o = ~clk_o;
    end

    // real falling edge on reset so the async flops see it
    initial begin
        rst_n_o = 1'b1;
        #1 rst_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk_o);
        #10 rst_n_o = 1'b1;                     // release off the edge
    end

endmodule

`default_nettype wire

// ==== rv_idex_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_idex_defines.svh"

module rv_idex_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   redirect_i,
    input logic                   wb_valid_i,
    input logic [`REG_ADDR_W-1:0] wb_waddr_i,
    input logic                   halt_i
);

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halt_i |=> halt_i)
        else $error("halt_o dropped without a reset");

    // the younger instruction is always flushed
    redirect_single: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_i |=> !redirect_i)
        else $error("redirect_o high in two consecutive cycles");

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_i |-> (wb_waddr_i != '0))
        else $error("writeback reported for x0");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!redirect_i && !wb_valid_i && !halt_i))
        else $error("outputs active during reset");

endmodule

`default_nettype wire

// ==== rv_idex_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_idex_defines.svh"

module rv_idex_monitor (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_valid_i,
    input  logic [`REG_ADDR_W-1:0] wb_waddr_i,
    input  logic [`XLEN-1:0]       wb_wdata_i,
    input  logic                   redirect_i,
    input  logic [`XLEN-1:0]       redirect_pc_i,
    input  logic                   halt_i,
    input  logic                   exp_wb_push_i,
    input  logic [`REG_ADDR_W-1:0] exp_wb_addr_i,
    input  logic [`XLEN-1:0]       exp_wb_data_i,
    input  logic                   exp_rd_push_i,
    input  logic [`XLEN-1:0]       exp_rd_pc_i,
    output logic [31:0]            pending_o,
    output logic [31:0]            errors_o,
    output logic [31:0]            wb_seen_o,
    output logic [31:0]            rd_seen_o
);

    logic [`REG_ADDR_W-1:0] exp_addr_q [$];
    logic [`XLEN-1:0]       exp_data_q [$];
    logic [`XLEN-1:0]       exp_pc_q [$];
    logic [`REG_ADDR_W-1:0] exp_addr;
    logic [`XLEN-1:0]       exp_data;
    logic [`XLEN-1:0]       exp_pc;
    int                     errors = 0;
    int                     wb_seen = 0;
    int                     rd_seen = 0;
    int                     pending = 0;

    // sampled mid-cycle where outputs and push strobes have settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (exp_wb_push_i) begin
                exp_addr_q.push_back(exp_wb_addr_i);
                exp_data_q.push_back(exp_wb_data_i);
            end
            if (exp_rd_push_i) begin
                exp_pc_q.push_back(exp_rd_pc_i);
            end
            if (wb_valid_i) begin
                wb_seen++;
                if (exp_addr_q.size() == 0) begin
                    $display("unexpected writeback to x%0d at %0t", wb_waddr_i, $time);
                    errors++;
                end else begin
                    exp_addr = exp_addr_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    if (wb_waddr_i !== exp_addr) begin
                        $display("FAIL t=%0t wb_waddr_o expected %0d got %0d",
                                 $time, exp_addr, wb_waddr_i);
                        errors++;
                    end
                    if (wb_wdata_i !== exp_data) begin
                        $display("FAIL t=%0t wb_wdata_o expected %h got %h",
                                 $time, exp_data, wb_wdata_i);
                        errors++;
                    end
                end
            end
            if (redirect_i) begin
                rd_seen++;
                if (exp_pc_q.size() == 0) begin
                    $display("unexpected redirect to %h at %0t", redirect_pc_i, $time);
                    errors++;
                end else begin
                    exp_pc = exp_pc_q.pop_front();
                    if (redirect_pc_i !== exp_pc) begin
                        $display("FAIL t=%0t redirect_pc_o expected %h got %h",
                                 $time, exp_pc, redirect_pc_i);
                        errors++;
                    end
                end
            end
            if (halt_i && (wb_valid_i || redirect_i)) begin
                $display("pipeline still active after halt at %0t", $time);
                errors++;
            end
            pending = exp_addr_q.size() + exp_pc_q.size();
        end
    end

    assign pending_o = pending;
    assign errors_o  = errors;
    assign wb_seen_o = wb_seen;
    assign rd_seen_o = rd_seen;

endmodule

`default_nettype wire

// ==== rv_idex_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rv_idex_defines.svh"

module rv_idex_tb;

    localparam int n_instr    = 2000;
    localparam int n_tail     = 20;
    localparam int wait_limit = 10000;
    localparam int k_ebreak   = 12;

    logic                   clk;
    logic                   rst_n;
    logic                   instr_valid;
    logic [31:0]            instr;
    logic [`XLEN-1:0]       pc_in;
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_waddr;
    logic [`XLEN-1:0]       wb_wdata;
    logic                   halt;
    logic                   exp_wb_push;
    logic [`REG_ADDR_W-1:0] exp_wb_addr;
    logic [`XLEN-1:0]       exp_wb_data;
    logic                   exp_rd_push;
    logic [`XLEN-1:0]       exp_rd_pc;
    logic [31:0]            mon_pending;
    logic [31:0]            mon_errors;
    logic [31:0]            mon_wb_seen;
    logic [31:0]            mon_rd_seen;

    // reference isa state
    logic [`XLEN-1:0]       xreg [`REG_DEPTH];
    logic [`XLEN-1:0]       cur_pc;
    logic                   prev_redirect;
    logic                   halted_model;
    int                     tb_errors;

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv_idex_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .pc_i          (pc_in),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .wb_valid_o    (wb_valid),
        .wb_waddr_o    (wb_waddr),
        .wb_wdata_o    (wb_wdata),
        .halt_o        (halt)
    );

    rv_idex_monitor u_monitor (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb_valid_i    (wb_valid),
        .wb_waddr_i    (wb_waddr),
        .wb_wdata_i    (wb_wdata),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .halt_i        (halt),
        .exp_wb_push_i (exp_wb_push),
        .exp_wb_addr_i (exp_wb_addr),
        .exp_wb_data_i (exp_wb_data),
        .exp_rd_push_i (exp_rd_push),
        .exp_rd_pc_i   (exp_rd_pc),
        .pending_o     (mon_pending),
        .errors_o      (mon_errors),
        .wb_seen_o     (mon_wb_seen),
        .rd_seen_o     (mon_rd_seen)
    );

    bind rv_idex_top rv_idex_checker u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect_i (redirect_o),
        .wb_valid_i (wb_valid_o),
        .wb_waddr_i (wb_waddr_o),
        .halt_i     (halt_o)
    );

    // mostly x0..x7 so that back to back dependencies are common
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = $urandom;
        if (r[31:30] != 2'b00) begin
            return {2'b00, r[2:0]};
        end
        return r[4:0];
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b000, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // builds one slot and runs it through the model before driving it
    task automatic issue_instr(input logic valid, input int kind);
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [11:0]      imm12;
        logic [19:0]      imm20;
        logic [12:0]      imm13;
        logic [20:0]      imm21;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] tgt;
        logic [`XLEN-1:0] i_ext;
        logic [31:0]      word;
        logic             wr;
        logic             redir;
        logic             live;
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        imm12 = 12'($urandom);
        imm20 = 20'($urandom);
        imm13 = {12'($urandom), 1'b0};
        imm21 = {20'($urandom), 1'b0};
        i_ext = {{52{imm12[11]}}, imm12};
        a     = xreg[rs1];
        b     = xreg[rs2];
        wr    = 1'b1;
        redir = 1'b0;
        tgt   = '0;
        res   = '0;
        case (kind)
            0: begin
                word = enc_r(7'h00, rs2, rs1, 3'b000, rd);
                res  = a + b;
            end
            1: begin
                word = enc_r(7'h20, rs2, rs1, 3'b000, rd);
                res  = a - b;
            end
            2: begin
                word = enc_r(7'h00, rs2, rs1, 3'b111, rd);
                res  = a & b;
            end
            3: begin
                word = enc_r(7'h00, rs2, rs1, 3'b110, rd);
                res  = a | b;
            end
            4: begin
                word = enc_r(7'h00, rs2, rs1, 3'b100, rd);
                res  = a ^ b;
            end
            5: begin
                word = enc_r(7'h00, rs2, rs1, 3'b010, rd);
                res  = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            end
            6: begin
                word = enc_i(imm12, rs1, rd, 7'b0010011);
                res  = a + i_ext;
            end
            7: begin
                word = {imm20, rd, 7'b0110111};
                res  = {{32{imm20[19]}}, imm20, 12'h000};
            end
            8, 9: begin
                word  = enc_b(imm13, rs2, rs1, (kind == 9) ? 3'b001 : 3'b000);
                wr    = 1'b0;
                redir = (kind == 9) ? (a != b) : (a == b);
                tgt   = cur_pc + {{51{imm13[12]}}, imm13};
            end
            10: begin
                word  = enc_j(imm21, rd);
                res   = cur_pc + 64'd4;
                redir = 1'b1;
                tgt   = cur_pc + {{43{imm21[20]}}, imm21};
            end
            11: begin
                word  = enc_i(imm12, rs1, rd, 7'b1100111);
                res   = cur_pc + 64'd4;
                redir = 1'b1;
                tgt   = (a + i_ext) & ~64'd1;           // old rs1 even if rd == rs1
            end
            default: begin
                word = 32'h0010_0073;
                wr   = 1'b0;
            end
        endcase
        live        = valid && !prev_redirect && !halted_model;
        instr_valid = valid;
        instr       = word;
        pc_in       = cur_pc;
        exp_wb_push = live && wr && (rd != 5'd0);
        exp_wb_addr = rd;
        exp_wb_data = res;
        exp_rd_push = live && redir;
        exp_rd_pc   = tgt;
        if (exp_wb_push) begin
            xreg[rd] = res;
        end
        if (live && (kind == k_ebreak)) begin
            halted_model = 1'b1;
        end
        prev_redirect = live && redir;
        cur_pc        = cur_pc + 64'd4;
    endtask

    task automatic drive_idle();
        instr_valid = 1'b0;
        instr       = '0;
        exp_wb_push = 1'b0;
        exp_rd_push = 1'b0;
    endtask

    initial begin
        int cnt;
        void'($urandom(47281));
        instr_valid   = 1'b0;
        instr         = '0;
        pc_in         = '0;
        exp_wb_push   = 1'b0;
        exp_wb_addr   = '0;
        exp_wb_data   = '0;
        exp_rd_push   = 1'b0;
        exp_rd_pc     = '0;
        cur_pc        = `RESET_PC;
        prev_redirect = 1'b0;
        halted_model  = 1'b0;
        tb_errors     = 0;
        for (int i = 0; i < `REG_DEPTH; i++) begin
            xreg[i] = '0;
        end

        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while ((rst_n !== 1'b1) && (cnt < wait_limit));
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            tb_errors++;
        end

        for (int i = 0; i < n_instr; i++) begin
            @(posedge clk);
            #10;
            issue_instr(($urandom % 100) < 80, int'($urandom % 12));
        end
        // two empty slots so no older redirect can flush the ebreak
        repeat (2) begin
            @(posedge clk);
            #10;
            issue_instr(1'b0, 0);
        end
        if (halt) begin
            $display("halt_o went high before EBREAK was issued");
            tb_errors++;
        end
        @(posedge clk);
        #10;
        issue_instr(1'b1, k_ebreak);
        for (int i = 0; i < n_tail; i++) begin
            @(posedge clk);
            #10;
            issue_instr(1'b1, int'($urandom % 12));
        end
        @(posedge clk);
        #10;
        drive_idle();

        cnt = 0;
        while (!halt && (cnt < wait_limit)) begin
            @(posedge clk);
            cnt++;
        end
        if (!halt) begin
            $display("halt_o never rose after EBREAK");
            tb_errors++;
        end
        cnt = 0;
        while ((mon_pending != 0) && (cnt < wait_limit)) begin
            @(posedge clk);
            cnt++;
        end
        if (mon_pending != 0) begin
            $display("%0d expected events never appeared at the outputs", mon_pending);
            tb_errors++;
        end
        repeat (20) @(posedge clk);                 // quiet window after halt
        if (!halt) begin
            $display("halt_o did not stay high");
            tb_errors++;
        end
        if ((mon_wb_seen < 100) || (mon_rd_seen < 20)) begin
            $display("too few writebacks or redirects seen to trust the run");
            tb_errors++;
        end

        $display("writebacks %0d, redirects %0d, monitor errors %0d, testbench errors %0d",
                 mon_wb_seen, mon_rd_seen, mon_errors, tb_errors);
        if ((mon_errors == 0) && (tb_errors == 0)) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_idex.f ====
+incdir+.
rv_idex_pkg.sv
inst_decoder.sv
reg_file.sv
pipe_reg.sv
alu_exec.sv
hazard_ctrl.sv
rv_idex_top.sv
tb_clock_gen.sv
rv_idex_checker.sv
rv_idex_monitor.sv
rv_idex_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f rv_idex.f --top-module rv_idex_tb \
    -o sim_rv_idex || exit 1
./obj_dir/sim_rv_idex > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log && ! grep -q "simulator returned an error" sim.log || exit 1
